//--- build.f
+incdir+common
common/memPkg.sv
hdl/byteRam.sv
hdl/ioFifo.sv
hdl/ioPort.sv
memCtrl/memCtrl.sv
hdl/memSys.sv
dv/memSysTb.sv

//--- common/memPkg.sv
`default_nettype none

`include "mem_macros.svh"

package memPkg;

    typedef logic [`MEM_ADDR_BITS-1:0] memAddrT;
    typedef logic [31:0] memWordT;
    typedef logic [7:0] memByteT;

    // 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        accByte,
        accHalf,
        accWord
    } accessLenT;

    typedef struct packed {
        logic      store;
        accessLenT len;
        memAddrT   addr;
        memWordT   wdata;
    } dataReqT;

    // done is a one-cycle strobe
    typedef struct packed {
        logic    done;
        memWordT rdata;
    } memRespT;

    typedef struct packed {
        logic    write;
        memAddrT addr;
        memByteT wdata;
    } ramCmdT;

    typedef struct packed {
        logic    valid;
        memByteT data;
    } ioByteT;

endpackage

`default_nettype wire

//--- common/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// byte address width
`define MEM_ADDR_BITS 17

// top address bit selects the I/O region
`define MEM_IO_BIT (`MEM_ADDR_BITS - 1)

// lower half of the address space is RAM
`define RAM_DEPTH 65536

// I/O output buffering
`define IO_FIFO_DEPTH 4

// cycles between two bytes leaving the output port
`define IO_DRAIN_CYCLES 6

`endif

//--- dv/memSysTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module memSysTb import memPkg::*; ();

    localparam int RamIdxBits  = $clog2(`RAM_DEPTH);
    localparam int DoneTimeout = 200;
    localparam int WinBytes    = 64;

    logic    clk = 1'b0;
    logic    rst;
    logic    fetchReq;
    memAddrT fetchAddr;
    logic    dataReqValid;
    dataReqT dataReq;
    memRespT fetchResp;
    memRespT dataResp;
    ioByteT  ioOut;

    // mirror of every RAM store issued
    memByteT shadow [`RAM_DEPTH];
    memByteT expIo [$];
    memByteT expByte;
    memAddrT base;
    int      valueErrs = 0;
    int      otherErrs = 0;
    int      cycleCnt = 0;
    int      lastIoCycle = 0;
    logic    ioSeen = 1'b0;
    int      ioMaxCycles = 0;
    int      waitCyc;

    memSys dut (
        .clk          (clk),
        .rst          (rst),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .dataReqValid (dataReqValid),
        .dataReq      (dataReq),
        .fetchResp    (fetchResp),
        .dataResp     (dataResp),
        .ioOut        (ioOut)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    function automatic int byteCount(input accessLenT len);
        if (len == accByte) return 1;
        if (len == accHalf) return 2;
        return 4;
    endfunction

    function automatic logic [RamIdxBits-1:0] ramIdx(input memAddrT a, input int i);
        return RamIdxBits'(a + memAddrT'(i));
    endfunction

    // expected little-endian word, upper bytes zero
    function automatic memWordT refWord(input memAddrT addr, input int n);
        memWordT w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[ramIdx(addr, i)];
        end
        return w;
    endfunction

    task automatic expectEq(input string name, input memWordT got, input memWordT exp);
        assert (got == exp) else begin
            valueErrs++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic expectLow(input string name, input logic v);
        assert (v == 1'b0) else begin
            valueErrs++;
            $display("CHECK FAILED at %0t: %s got %b expected 0", $time, name, v);
        end
    endtask

    // samples mid-cycle, cycle 1 is the cycle the request is raised
    task automatic waitDone(input logic fetchSide, output int cycles, output memWordT rdata);
        int      cyc;
        logic    seen;
        memRespT resp;
        seen = 1'b0;
        cyc = 1;
        cycles = 0;
        rdata = '0;
        while (!seen && cyc <= DoneTimeout) begin
            #1;
            resp = fetchSide ? fetchResp : dataResp;
            if (resp.done) begin
                seen = 1'b1;
                cycles = cyc;
                rdata = resp.rdata;
            end else begin
                @(negedge clk);
                cyc++;
            end
        end
        if (!seen) begin
            otherErrs++;
            $display("timeout at %0t: %s request got no done within %0d cycles", $time,
                     fetchSide ? "fetch" : "data", DoneTimeout);
        end
    endtask

    task automatic dataAccess(input logic store, input accessLenT len, input memAddrT addr,
                              input memWordT wdata);
        int      n;
        int      cycles;
        logic    toIo;
        memWordT rdata;
        memWordT expWord;
        n = byteCount(len);
        toIo = addr[`MEM_IO_BIT];
        expWord = '0;
        if (store) begin
            for (int i = 0; i < n; i++) begin
                if (toIo) expIo.push_back(wdata[8*i +: 8]);
                else shadow[ramIdx(addr, i)] = wdata[8*i +: 8];
            end
        end else begin
            expWord = refWord(addr, n);
        end
        dataReqValid = 1'b1;
        dataReq = '{store: store, len: len, addr: addr, wdata: wdata};
        waitDone(1'b0, cycles, rdata);
        if (cycles != 0) begin
            if (!store) expectEq("dataResp.rdata", rdata, expWord);
            if (!toIo) expectEq("data done cycle", cycles, store ? n : n + 1);
            if (toIo && cycles > ioMaxCycles) begin
                ioMaxCycles = cycles;
            end
        end
        // lowered in the recovery cycle, next request one cycle later
        @(negedge clk);
        dataReqValid = 1'b0;
        @(negedge clk);
    endtask

    task automatic fetchWord(input memAddrT addr);
        int      cycles;
        memWordT rdata;
        memWordT expWord;
        expWord = refWord(addr, 4);
        fetchReq = 1'b1;
        fetchAddr = addr;
        waitDone(1'b1, cycles, rdata);
        if (cycles != 0) begin
            expectEq("fetchResp.rdata", rdata, expWord);
            expectEq("fetch done cycle", cycles, 5);
        end
        @(negedge clk);
        fetchReq = 1'b0;
        @(negedge clk);
    endtask

    // data load and fetch raised together
    task automatic raceAccess(input memAddrT dAddr, input memAddrT fAddr);
        int      cyc;
        int      dCyc;
        int      fCyc;
        memWordT dExp;
        memWordT fExp;
        dExp = refWord(dAddr, 4);
        fExp = refWord(fAddr, 4);
        dataReqValid = 1'b1;
        dataReq = '{store: 1'b0, len: accWord, addr: dAddr, wdata: '0};
        fetchReq = 1'b1;
        fetchAddr = fAddr;
        dCyc = 0;
        fCyc = 0;
        cyc = 1;
        while (fCyc == 0 && cyc <= DoneTimeout) begin
            #1;
            if (dataResp.done) begin
                dCyc = cyc;
                expectEq("dataResp.rdata", dataResp.rdata, dExp);
            end
            if (fetchResp.done) begin
                fCyc = cyc;
                expectEq("fetchResp.rdata", fetchResp.rdata, fExp);
            end
            @(negedge clk);
            cyc++;
            if (dCyc != 0) dataReqValid = 1'b0;
        end
        assert (dCyc != 0 && fCyc > dCyc) else begin
            otherErrs++;
            $display("at %0t: data done (cycle %0d) did not come before fetch done (cycle %0d)",
                     $time, dCyc, fCyc);
        end
        fetchReq = 1'b0;
        dataReqValid = 1'b0;
        @(negedge clk);
    endtask

    // compares each output byte with the oldest expected one
    always @(negedge clk) begin
        if (!rst && ioOut.valid) begin
            if (expIo.size() == 0) begin
                otherErrs++;
                $display("at %0t: unexpected I/O byte %0h on ioOut", $time, ioOut.data);
            end else begin
                expByte = expIo.pop_front();
                expectEq("ioOut.data", memWordT'(ioOut.data), memWordT'(expByte));
            end
            if (ioSeen) begin
                assert (cycleCnt - lastIoCycle >= `IO_DRAIN_CYCLES) else begin
                    otherErrs++;
                    $display("at %0t: ioOut strobes only %0d cycles apart", $time,
                             cycleCnt - lastIoCycle);
                end
            end
            lastIoCycle = cycleCnt;
            ioSeen = 1'b1;
        end
    end

    initial begin
        void'($urandom(32'h94331471));
        rst = 1'b1;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReqValid = 1'b0;
        dataReq = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        repeat (8) begin
            #1;
            expectLow("fetchResp.done", fetchResp.done);
            expectLow("dataResp.done", dataResp.done);
            expectLow("ioOut.valid", ioOut.valid);
            @(negedge clk);
        end

        // fill a RAM window so every later load reads defined bytes
        base = memAddrT'($urandom % (`RAM_DEPTH - WinBytes));
        for (int i = 0; i < WinBytes; i += 4) begin
            dataAccess(1'b1, accWord, base + memAddrT'(i), $urandom);
        end
        for (int i = 0; i < 24; i++) begin
            dataAccess(1'b1, accessLenT'(i % 3),
                       base + memAddrT'($urandom % (WinBytes - 3)), $urandom);
        end
        for (int i = 0; i < 24; i++) begin
            dataAccess(1'b0, accessLenT'(i % 3),
                       base + memAddrT'($urandom % (WinBytes - 3)), '0);
        end
        for (int i = 0; i < 8; i++) begin
            fetchWord(base + memAddrT'($urandom % (WinBytes - 3)));
        end
        for (int i = 0; i < 3; i++) begin
            raceAccess(base + memAddrT'($urandom % (WinBytes - 3)),
                       base + memAddrT'($urandom % (WinBytes - 3)));
        end

        // enough I/O words to fill the FIFO and stall
        for (int i = 0; i < 6; i++) begin
            dataAccess(1'b1, accWord, memAddrT'(32'h10000 + 4 * i), $urandom);
        end
        // a word store without a stall is done in cycle 4
        assert (ioMaxCycles > 4) else begin
            otherErrs++;
            $display("I/O stores never stalled on a full FIFO");
        end
        waitCyc = 0;
        while (expIo.size() != 0 && waitCyc < 400) begin
            @(negedge clk);
            waitCyc++;
        end
        if (expIo.size() != 0) begin
            otherErrs++;
            $display("timeout: %0d I/O bytes never left the output port", expIo.size());
        end
        repeat (2 * `IO_DRAIN_CYCLES) @(negedge clk);

        $display("value errors: %0d, other errors: %0d", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/byteRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module byteRam import memPkg::*; (
    input  logic    clk,
    input  ramCmdT  ramCmd,
    output memByteT ramRdata
);

    localparam int RamIdxBits = $clog2(`RAM_DEPTH);

    memByteT mem [`RAM_DEPTH];

    logic [RamIdxBits-1:0] idx;

    // upper address bits select the I/O region, not RAM
    assign idx = ramCmd.addr[RamIdxBits-1:0];

    // read data appears one cycle after the command
    always_ff @(posedge clk) begin
        if (ramCmd.write) begin
            mem[idx] <= ramCmd.wdata;
        end else begin
            ramRdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- hdl/ioFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module ioFifo import memPkg::*; #(
    parameter int depth = `IO_FIFO_DEPTH
) (
    input  logic    clk,
    input  logic    rst,
    input  ioByteT  push,
    input  logic    pop,
    output memByteT head,
    output logic    full,
    output logic    empty
);

    localparam int PtrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam int CntBits = $clog2(depth + 1);

    memByteT slots [depth];

    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [CntBits-1:0] count;
    logic               doPush;
    logic               doPop;

    assign full   = (count == CntBits'(depth));
    assign empty  = (count == '0);
    assign doPush = push.valid && !full;
    assign doPop  = pop && !empty;
    assign head   = slots[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= push.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrBits'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrBits'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop leave the count alone
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else $error("pop from an empty I/O FIFO");

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        push.valid |-> !full)
        else $error("push into a full I/O FIFO");

endmodule

`default_nettype wire

//--- hdl/ioPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module ioPort import memPkg::*; #(
    parameter int drainCycles = `IO_DRAIN_CYCLES
) (
    input  logic    clk,
    input  logic    rst,
    input  memByteT head,
    input  logic    empty,
    output logic    pop,
    output ioByteT  ioOut
);

    localparam int CntBits = $clog2(drainCycles + 1);

    logic [CntBits-1:0] paceCnt;
    logic               outValid;
    memByteT            outData;

    // slow character output, at most one byte per drainCycles
    assign pop = !empty && (paceCnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            paceCnt  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= pop;
            if (pop) begin
                paceCnt <= CntBits'(drainCycles - 1);
            end else if (paceCnt != '0) begin
                paceCnt <= paceCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            outData <= head;
        end
    end

    assign ioOut = '{valid: outValid, data: outData};

endmodule

`default_nettype wire

//--- hdl/memSys.sv
`timescale 1ns/1ps
`default_nettype none

module memSys import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    fetchReq,
    input  memAddrT fetchAddr,
    input  logic    dataReqValid,
    input  dataReqT dataReq,
    output memRespT fetchResp,
    output memRespT dataResp,
    output ioByteT  ioOut
);

    ramCmdT  ramCmd;
    memByteT ramRdata;
    ioByteT  ioPush;
    logic    ioFull;
    logic    ioEmpty;
    logic    ioPop;
    memByteT ioHead;

    memCtrl u_memCtrl (
        .clk          (clk),
        .rst          (rst),
        .fetchReq     (fetchReq),
        .fetchAddr    (fetchAddr),
        .dataReqValid (dataReqValid),
        .dataReq      (dataReq),
        .fetchResp    (fetchResp),
        .dataResp     (dataResp),
        .ramCmd       (ramCmd),
        .ramRdata     (ramRdata),
        .ioPush       (ioPush),
        .ioFull       (ioFull)
    );

    byteRam u_byteRam (
        .clk      (clk),
        .ramCmd   (ramCmd),
        .ramRdata (ramRdata)
    );

    ioFifo u_ioFifo (
        .clk   (clk),
        .rst   (rst),
        .push  (ioPush),
        .pop   (ioPop),
        .head  (ioHead),
        .full  (ioFull),
        .empty (ioEmpty)
    );

    ioPort u_ioPort (
        .clk   (clk),
        .rst   (rst),
        .head  (ioHead),
        .empty (ioEmpty),
        .pop   (ioPop),
        .ioOut (ioOut)
    );

endmodule

`default_nettype wire

//--- memCtrl/memCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_macros.svh"

module memCtrl import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    fetchReq,
    input  memAddrT fetchAddr,
    input  logic    dataReqValid,
    input  dataReqT dataReq,
    output memRespT fetchResp,
    output memRespT dataResp,
    output ramCmdT  ramCmd,
    input  memByteT ramRdata,
    output ioByteT  ioPush,
    input  logic    ioFull
);

    function automatic logic [2:0] lenBytes(input accessLenT len);
        case (len)
            accByte: return 3'd1;
            accHalf: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    logic       busy;
    logic       ownerFetch;
    logic       recover;
    logic [2:0] stage;

    // load bytes gathered so far
    logic [3:0][7:0] wordBytes;

    logic            grantData;
    logic            grantFetch;
    logic            active;
    logic            curFetch;
    logic            curStore;
    logic [2:0]      nBytes;
    logic [2:0]      prevStage;
    memAddrT         baseAddr;
    memAddrT         byteAddr;
    memAddrT         prevAddr;
    logic            byteIo;
    logic            ioStall;
    logic            doneNow;
    memByteT         inByte;
    logic [3:0][7:0] storeBytes;
    logic [3:0][7:0] assembled;
    memWordT         loadWord;

    // data wins over fetch, nothing is granted in the recovery cycle
    assign grantData  = !busy && !recover && dataReqValid;
    assign grantFetch = !busy && !recover && !dataReqValid && fetchReq;
    assign active     = busy || grantData || grantFetch;
    assign curFetch   = busy ? ownerFetch : grantFetch;
    assign curStore   = !curFetch && dataReq.store;
    assign nBytes     = curFetch ? 3'd4 : lenBytes(dataReq.len);

    // requests are held, so the base address is taken from the inputs
    assign baseAddr   = curFetch ? fetchAddr : dataReq.addr;
    assign prevStage  = stage - 3'd1;
    assign byteAddr   = baseAddr + memAddrT'(stage);
    assign prevAddr   = baseAddr + memAddrT'(prevStage);
    assign byteIo     = byteAddr[`MEM_IO_BIT];
    assign storeBytes = dataReq.wdata;

    // an I/O byte cannot leave while the FIFO is full
    assign ioStall = active && curStore && byteIo && ioFull;

    always_comb begin
        doneNow = 1'b0;
        if (active) begin
            if (curStore) begin
                doneNow = (stage == nBytes - 3'd1) && !ioStall;
            end else begin
                doneNow = (stage == nBytes);
            end
        end
    end

    // byte read in the previous cycle, I/O region reads as zero
    assign inByte = prevAddr[`MEM_IO_BIT] ? 8'h00 : ramRdata;

    // last byte comes straight from the RAM in the done cycle
    always_comb begin
        assembled = wordBytes;
        assembled[prevStage[1:0]] = inByte;
        case (nBytes)
            3'd1:    loadWord = {24'h0, assembled[0]};
            3'd2:    loadWord = {16'h0, assembled[1:0]};
            default: loadWord = assembled;
        endcase
    end

    assign fetchResp = '{done: doneNow && curFetch, rdata: loadWord};
    assign dataResp  = '{done: doneNow && !curFetch, rdata: loadWord};

    assign ramCmd = '{
        write: active && curStore && !byteIo,
        addr:  byteAddr,
        wdata: storeBytes[stage[1:0]]
    };

    assign ioPush = '{
        valid: active && curStore && byteIo && !ioFull,
        data:  storeBytes[stage[1:0]]
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            ownerFetch <= 1'b0;
            recover    <= 1'b0;
            stage      <= 3'd0;
        end else begin
            recover <= doneNow;
            if (doneNow) begin
                busy  <= 1'b0;
                stage <= 3'd0;
            end else if (active) begin
                busy <= 1'b1;
                if (!ioStall) begin
                    stage <= stage + 3'd1;
                end
            end
            // owner is latched at the grant
            if (!busy) begin
                ownerFetch <= grantFetch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (active && !curStore && stage != 3'd0) begin
            wordBytes[prevStage[1:0]] <= inByte;
        end
    end

    // base address and length come from the held data request
    heldDataReq: assert property (@(posedge clk) disable iff (rst)
        (busy && !ownerFetch) |-> $stable(dataReq))
        else $error("data request changed before its done");

    // no access starts in the recovery cycle
    recoveryIdle: assert property (@(posedge clk) disable iff (rst)
        (fetchResp.done || dataResp.done) |=> !active)
        else $error("access active in the cycle after a done");

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds and runs the memSys testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f build.f --top-module memSysTb > build.log 2>&1 \
    && ./obj_dir/VmemSysTb > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qx "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -qx "ALL CHECKS PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
